// File: design/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data and pc width
`define RV_XLEN 32
// register index width and count
`define RV_REG_AW 5
`define RV_NUM_REGS 32
// first fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

`endif

// File: design/rv_pkg.sv
`include "rv_params.svh"

package rv_pkg;

	typedef logic [`RV_XLEN-1:0] word_t;
	typedef logic [`RV_REG_AW-1:0] reg_addr_t;

	// major opcodes of the supported subset
	localparam logic [6:0] opc_op = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_lui = 7'b0110111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_jal = 7'b1101111;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_pass_b
	} alu_op_e;

	typedef enum logic [1:0] {
		imm_i,
		imm_b,
		imm_u,
		imm_j
	} imm_kind_e;

	typedef enum logic [1:0] {
		fwd_rf,
		fwd_mem,
		fwd_wb
	} fwd_sel_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic use_imm;
		logic reg_write;
		logic branch;
		logic branch_ne;
		logic jump;
	} ctrl_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		word_t instr;
		logic predicted_taken;
	} fd_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		word_t rs1_data;
		word_t rs2_data;
		word_t imm;
		ctrl_t ctrl;
		logic predicted_taken;
	} de_t;

	// also used for the memory-to-writeback register
	typedef struct packed {
		logic valid;
		word_t pc;
		reg_addr_t rd;
		logic reg_write;
		word_t result;
	} em_t;

	typedef struct packed {
		logic valid;
		word_t target;
	} redirect_t;

	typedef struct packed {
		logic valid;
		logic taken;
	} bp_update_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		reg_addr_t rd;
		word_t data;
	} retire_t;

endpackage

// File: design/rv_fetch.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_fetch import rv_pkg::*; (
	input logic clk,
	input logic rstn,
	input word_t instr,
	input redirect_t redirect,
	input bp_update_t bp_update,
	input logic flush,
	output word_t pcf,
	output fd_t fd
);

	logic [1:0] bp_cnt;
	logic is_jal;
	logic is_branch;
	logic predict_taken;
	word_t imm_j;
	word_t imm_b;
	word_t pc_next;

	// just enough decode to steer the next pc
	assign is_jal = (instr[6:0] == opc_jal);
	assign is_branch = (instr[6:0] == opc_branch);
	assign predict_taken = is_branch && bp_cnt[1];

	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

	// execute redirect wins over anything seen in fetch
	always_comb begin
		if (redirect.valid) begin
			pc_next = redirect.target;
		end else if (is_jal) begin
			pc_next = pcf + imm_j;
		end else if (predict_taken) begin
			pc_next = pcf + imm_b;
		end else begin
			pc_next = pcf + word_t'(4);
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			pcf <= `RV_RESET_PC;
		end else begin
			pcf <= pc_next;
		end
	end

	// global 2-bit saturating counter, strongly taken out of reset
	always_ff @(posedge clk) begin
		if (!rstn) begin
			bp_cnt <= 2'b11;
		end else if (bp_update.valid) begin
			if (bp_update.taken && bp_cnt != 2'b11) begin
				bp_cnt <= bp_cnt + 2'b01;
			end else if (!bp_update.taken && bp_cnt != 2'b00) begin
				bp_cnt <= bp_cnt - 2'b01;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn || flush) begin
			fd.valid <= 1'b0;
		end else begin
			fd.valid <= 1'b1;
		end
		fd.pc <= pcf;
		fd.instr <= instr;
		fd.predicted_taken <= predict_taken;
	end

endmodule

// File: design/rv_decode.sv
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
	input logic clk,
	input logic rstn,
	input fd_t fd,
	input logic flush,
	output reg_addr_t rs1,
	output reg_addr_t rs2,
	input word_t rs1_data,
	input word_t rs2_data,
	output de_t de
);

	word_t instr;
	ctrl_t ctrl;
	imm_kind_e imm_kind;
	word_t imm;
	logic supported;

	assign instr = fd.instr;
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = alu_add;
		imm_kind = imm_i;
		supported = 1'b1;
		case (instr[6:0])
			opc_op: begin
				ctrl.reg_write = 1'b1;
				case ({instr[31:25], instr[14:12]})
					{7'h00, 3'b000}: ctrl.alu_op = alu_add;
					{7'h20, 3'b000}: ctrl.alu_op = alu_sub;
					{7'h00, 3'b111}: ctrl.alu_op = alu_and;
					{7'h00, 3'b110}: ctrl.alu_op = alu_or;
					{7'h00, 3'b100}: ctrl.alu_op = alu_xor;
					{7'h00, 3'b010}: ctrl.alu_op = alu_slt;
					default: supported = 1'b0;
				endcase
			end
			// addi only
			opc_op_imm: begin
				ctrl.reg_write = 1'b1;
				ctrl.use_imm = 1'b1;
				supported = (instr[14:12] == 3'b000);
			end
			opc_lui: begin
				ctrl.reg_write = 1'b1;
				ctrl.use_imm = 1'b1;
				ctrl.alu_op = alu_pass_b;
				imm_kind = imm_u;
			end
			opc_branch: begin
				ctrl.branch = 1'b1;
				ctrl.branch_ne = instr[12];
				ctrl.alu_op = alu_sub;
				imm_kind = imm_b;
				supported = (instr[14:13] == 2'b00);
			end
			opc_jal: begin
				ctrl.reg_write = 1'b1;
				ctrl.jump = 1'b1;
				imm_kind = imm_j;
			end
			default: supported = 1'b0;
		endcase
	end

	always_comb begin
		case (imm_kind)
			imm_i: imm = {{20{instr[31]}}, instr[31:20]};
			imm_b: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			imm_u: imm = {instr[31:12], 12'b0};
			default: imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
		endcase
	end

	// unsupported encodings leave as bubbles
	always_ff @(posedge clk) begin
		if (!rstn || flush) begin
			de.valid <= 1'b0;
		end else begin
			de.valid <= fd.valid && supported;
		end
		de.pc <= fd.pc;
		de.rs1 <= rs1;
		de.rs2 <= rs2;
		de.rd <= instr[11:7];
		de.rs1_data <= rs1_data;
		de.rs2_data <= rs2_data;
		de.imm <= imm;
		de.ctrl <= ctrl;
		de.predicted_taken <= fd.predicted_taken;
	end

endmodule

// File: design/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_regfile import rv_pkg::*; (
	input logic clk,
	input logic rstn,
	input reg_addr_t rs1,
	input reg_addr_t rs2,
	output word_t rs1_data,
	output word_t rs2_data,
	input retire_t wb
);

	word_t regs [`RV_NUM_REGS];

	// x0 reads zero, a write in flight is seen by the read
	function automatic word_t read_port(reg_addr_t addr);
		if (addr == '0) begin
			return '0;
		end else if (wb.valid && wb.rd == addr) begin
			return wb.data;
		end
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < `RV_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid) begin
			regs[wb.rd] <= wb.data;
		end
	end

	always_comb begin
		rs1_data = read_port(rs1);
		rs2_data = read_port(rs2);
	end

endmodule

// File: design/rv_hazard.sv
`timescale 1ns/1ps

module rv_hazard import rv_pkg::*; (
	input de_t de,
	input em_t em,
	input em_t mw,
	input redirect_t redirect,
	output fwd_sel_e fwd_a,
	output fwd_sel_e fwd_b,
	output logic flush
);

	// youngest producer first, x0 is never forwarded
	function automatic fwd_sel_e pick_src(reg_addr_t src);
		if (src == '0) begin
			return fwd_rf;
		end else if (em.reg_write && em.rd == src) begin
			return fwd_mem;
		end else if (mw.reg_write && mw.rd == src) begin
			return fwd_wb;
		end
		return fwd_rf;
	endfunction

	always_comb begin
		fwd_a = pick_src(de.rs1);
		fwd_b = pick_src(de.rs2);
	end

	// kills fetch-to-decode and decode-to-execute together
	assign flush = redirect.valid;

endmodule

// File: design/rv_execute.sv
`timescale 1ns/1ps

module rv_execute import rv_pkg::*; (
	input logic clk,
	input logic rstn,
	input de_t de,
	input fwd_sel_e fwd_a,
	input fwd_sel_e fwd_b,
	input word_t mem_result,
	input word_t wb_result,
	output redirect_t redirect,
	output bp_update_t bp_update,
	output em_t em
);

	word_t op_a;
	word_t op_b;
	word_t alu_b;
	word_t alu_out;
	word_t pc_plus4;
	logic br_eq;
	logic br_taken;

	function automatic word_t fwd_pick(fwd_sel_e sel, word_t rf_val, word_t mem_val,
		word_t wb_val);
		case (sel)
			fwd_mem: return mem_val;
			fwd_wb: return wb_val;
			default: return rf_val;
		endcase
	endfunction

	assign op_a = fwd_pick(fwd_a, de.rs1_data, mem_result, wb_result);
	assign op_b = fwd_pick(fwd_b, de.rs2_data, mem_result, wb_result);
	assign alu_b = de.ctrl.use_imm ? de.imm : op_b;

	always_comb begin
		case (de.ctrl.alu_op)
			alu_add: alu_out = op_a + alu_b;
			alu_sub: alu_out = op_a - alu_b;
			alu_and: alu_out = op_a & alu_b;
			alu_or: alu_out = op_a | alu_b;
			alu_xor: alu_out = op_a ^ alu_b;
			alu_slt: alu_out = word_t'($signed(op_a) < $signed(alu_b));
			default: alu_out = alu_b;
		endcase
	end

	// beq and bne only
	assign br_eq = (op_a == op_b);
	assign br_taken = de.ctrl.branch && (de.ctrl.branch_ne ? !br_eq : br_eq);
	assign pc_plus4 = de.pc + word_t'(4);

	assign redirect.valid = de.valid && de.ctrl.branch && (br_taken != de.predicted_taken);
	assign redirect.target = br_taken ? de.pc + de.imm : pc_plus4;
	assign bp_update.valid = de.valid && de.ctrl.branch;
	assign bp_update.taken = br_taken;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			em.valid <= 1'b0;
			em.reg_write <= 1'b0;
		end else begin
			em.valid <= de.valid;
			em.reg_write <= de.valid && de.ctrl.reg_write;
		end
		em.pc <= de.pc;
		em.rd <= de.rd;
		// jal links the return address
		em.result <= de.ctrl.jump ? pc_plus4 : alu_out;
	end

endmodule

// File: design/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
	input logic clk,
	input logic rstn,
	input word_t instr,
	output word_t pcf,
	output retire_t retire
);

	fd_t fd;
	de_t de;
	em_t em;
	em_t mw;
	redirect_t redirect;
	bp_update_t bp_update;
	logic flush;
	fwd_sel_e fwd_a;
	fwd_sel_e fwd_b;
	reg_addr_t rs1;
	reg_addr_t rs2;
	word_t rs1_data;
	word_t rs2_data;

	rv_fetch u_fetch (.clk, .rstn, .instr, .redirect, .bp_update, .flush, .pcf, .fd);

	rv_decode u_decode (.clk, .rstn, .fd, .flush, .rs1, .rs2, .rs1_data, .rs2_data, .de);

	rv_regfile u_regfile (.clk, .rstn, .rs1, .rs2, .rs1_data, .rs2_data, .wb(retire));

	rv_hazard u_hazard (.de, .em, .mw, .redirect, .fwd_a, .fwd_b, .flush);

	rv_execute u_execute (.clk, .rstn, .de, .fwd_a, .fwd_b, .mem_result(em.result),
		.wb_result(mw.result), .redirect, .bp_update, .em);

	// memory stage has no work, so this register follows execute directly
	always_ff @(posedge clk) begin
		if (!rstn) begin
			mw.valid <= 1'b0;
			mw.reg_write <= 1'b0;
		end else begin
			mw.valid <= em.valid;
			mw.reg_write <= em.reg_write;
		end
		mw.pc <= em.pc;
		mw.rd <= em.rd;
		mw.result <= em.result;
	end

	assign retire.valid = mw.valid && mw.reg_write && (mw.rd != '0);
	assign retire.pc = mw.pc;
	assign retire.rd = mw.rd;
	assign retire.data = mw.result;

endmodule

// File: testbench/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
	output logic clk
);

	// 20 ns period
	localparam int HALF_PERIOD = 10;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

endmodule

// File: testbench/tb_rv_isa.svh
`ifndef TB_RV_ISA_SVH
`define TB_RV_ISA_SVH

// encoders for the supported subset
function automatic word_t alu_rr(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
	return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opc_op};
endfunction

function automatic word_t addi(int rd, int rs1, int imm);
	return {12'(imm), 5'(rs1), 3'b000, 5'(rd), opc_op_imm};
endfunction

function automatic word_t lui(int rd, int imm20);
	return {20'(imm20), 5'(rd), opc_lui};
endfunction

// ne selects bne over beq
function automatic word_t branch(logic ne, int rs1, int rs2, int off);
	logic [12:0] o;
	o = 13'(off);
	return {o[12], o[10:5], 5'(rs2), 5'(rs1), 2'b00, ne, o[4:1], o[11], opc_branch};
endfunction

function automatic word_t jal(int rd, int off);
	logic [20:0] o;
	o = 21'(off);
	return {o[20], o[10:1], o[11], o[19:12], 5'(rd), opc_jal};
endfunction

// in-order architectural model, one record per write to a register other than x0
task automatic run_model();
	word_t x [32];
	word_t pc;
	word_t next;
	word_t w;
	word_t a;
	word_t b;
	word_t val;
	logic wr;
	retire_t rec;
	int steps;
	foreach (x[i]) begin
		x[i] = '0;
	end
	exp_q.delete();
	pc = `RV_RESET_PC;
	steps = 0;
	w = imem_word(pc);
	// stops at the jal to itself that ends each program
	while (w != jal(0, 0) && steps < 1000) begin
		a = x[w[19:15]];
		b = x[w[24:20]];
		next = pc + 4;
		val = pc + 4;
		wr = 1'b1;
		case (w[6:0])
			opc_op: begin
				case ({w[30], w[14:12]})
					4'b1000: val = a - b;
					4'b0111: val = a & b;
					4'b0110: val = a | b;
					4'b0100: val = a ^ b;
					4'b0010: val = ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
					default: val = a + b;
				endcase
			end
			opc_op_imm: val = a + {{20{w[31]}}, w[31:20]};
			opc_lui: val = {w[31:12], 12'h000};
			opc_branch: begin
				wr = 1'b0;
				if ((a == b) != w[12]) begin
					next = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
				end
			end
			opc_jal: next = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			default: wr = 1'b0;
		endcase
		if (wr && w[11:7] != 5'd0) begin
			x[w[11:7]] = val;
			rec.valid = 1'b1;
			rec.pc = pc;
			rec.rd = w[11:7];
			rec.data = val;
			exp_q.push_back(rec);
		end
		pc = next;
		w = imem_word(pc);
		steps++;
	end
endtask

`endif

// File: testbench/tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module tb_rv_core import rv_pkg::*; ();

	localparam int MEM_WORDS = 64;
	localparam int CYCLES_PER_RETIRE = 50;
	// reset, pipeline fill and the quiet window after each test
	localparam int TEST_MARGIN = 60;
	localparam word_t NOP = 32'h0000_0013;

	logic clk;
	logic rstn;
	word_t instr;
	word_t pcf;
	retire_t retire;
	word_t imem [MEM_WORDS];
	retire_t exp_q [$];
	int budget = TEST_MARGIN;

	tb_clkgen u_clkgen (.clk);

	rv_core u_rv_core (.clk, .rstn, .instr, .pcf, .retire);

	// instruction memory answers in the same cycle
	assign instr = (pcf < 4 * MEM_WORDS) ? imem[pcf[7:2]] : NOP;

	function automatic word_t imem_word(word_t addr);
		if (addr < 4 * MEM_WORDS) begin
			return imem[addr[7:2]];
		end
		return NOP;
	endfunction

	`include "tb_rv_isa.svh"

	task automatic check_field(string field, word_t got, word_t want);
		assert (got === want) else begin
			$display("ERROR: %s got %h expected %h", field, got, want);
			$display("TESTBENCH FAILED");
			$fatal(1, "%s mismatch", field);
		end
	endtask

	// unused words hold nops tagged with their own address
	task automatic clear_program();
		for (int i = 0; i < MEM_WORDS; i++) begin
			imem[i] = addi(0, 0, i * 4);
		end
	endtask

	// ends at the negedge of the first cycle out of reset
	task automatic start_program();
		run_model();
		budget += CYCLES_PER_RETIRE * exp_q.size() + TEST_MARGIN;
		@(posedge clk);
		rstn <= 1'b0;
		repeat (5) @(posedge clk);
		rstn <= 1'b1;
		@(negedge clk);
	endtask

	task automatic compare_trace();
		int n;
		int idle;
		n = 0;
		idle = 0;
		while (n < exp_q.size()) begin
			if (retire.valid) begin
				check_field("retire.pc", retire.pc, exp_q[n].pc);
				check_field("retire.rd", word_t'(retire.rd), word_t'(exp_q[n].rd));
				check_field("retire.data", retire.data, exp_q[n].data);
				n++;
				idle = 0;
			end else begin
				idle++;
				assert (idle < CYCLES_PER_RETIRE) else begin
					$display("retire record %0d of %0d never arrived", n, exp_q.size());
					$display("TESTBENCH FAILED");
					$fatal(1, "missing retire record");
				end
			end
			@(negedge clk);
		end
		repeat (20) begin
			check_field("retire.valid", word_t'(retire.valid), '0);
			@(negedge clk);
		end
	endtask

	task automatic reset_state();
		clear_program();
		imem[0] = addi(1, 0, 5);
		imem[1] = addi(2, 1, -2);
		imem[2] = jal(0, 0);
		start_program();
		check_field("pcf", pcf, `RV_RESET_PC);
		// fetch to retire takes four cycles
		repeat (4) begin
			check_field("retire.valid", word_t'(retire.valid), '0);
			@(negedge clk);
		end
		check_field("retire.valid", word_t'(retire.valid), 1);
		compare_trace();
	endtask

	task automatic dependent_alu();
		clear_program();
		imem[0] = addi(1, 0, 7);
		imem[1] = addi(2, 1, 3);
		imem[2] = alu_rr(7'h00, 3'b000, 3, 1, 2);
		imem[3] = alu_rr(7'h20, 3'b000, 4, 3, 1);
		imem[4] = alu_rr(7'h00, 3'b100, 5, 4, 1);
		imem[5] = alu_rr(7'h00, 3'b111, 6, 5, 3);
		imem[6] = alu_rr(7'h00, 3'b110, 7, 6, 4);
		imem[7] = alu_rr(7'h00, 3'b010, 8, 4, 7);
		imem[8] = lui(9, 20'hfffff);
		imem[9] = alu_rr(7'h00, 3'b010, 10, 9, 1);
		imem[10] = addi(11, 9, -1);
		imem[11] = jal(0, 0);
		start_program();
		compare_trace();
	endtask

	task automatic x0_writes();
		clear_program();
		imem[0] = addi(0, 0, 9);
		imem[1] = alu_rr(7'h00, 3'b000, 1, 0, 0);
		imem[2] = lui(0, 20'h12345);
		imem[3] = addi(2, 0, 4);
		imem[4] = alu_rr(7'h00, 3'b110, 0, 2, 2);
		imem[5] = alu_rr(7'h00, 3'b000, 3, 0, 2);
		imem[6] = jal(0, 0);
		start_program();
		compare_trace();
	endtask

	task automatic jal_skip();
		clear_program();
		imem[0] = addi(1, 0, 1);
		imem[1] = jal(5, 12);
		imem[2] = addi(1, 1, 100);
		imem[3] = addi(2, 0, 55);
		imem[4] = alu_rr(7'h00, 3'b000, 3, 5, 1);
		imem[5] = jal(6, 8);
		imem[6] = addi(3, 0, -1);
		imem[7] = jal(0, 0);
		start_program();
		compare_trace();
	endtask

	task automatic branch_loops();
		clear_program();
		imem[0] = addi(1, 0, 3);
		imem[1] = addi(2, 2, 5);
		imem[2] = addi(1, 1, -1);
		imem[3] = branch(1'b1, 1, 0, -8);
		imem[4] = addi(8, 0, 3);
		imem[5] = addi(9, 0, 1);
		imem[6] = addi(3, 3, 1);
		imem[7] = alu_rr(7'h00, 3'b010, 4, 3, 8);
		imem[8] = branch(1'b0, 4, 9, -8);
		imem[9] = branch(1'b1, 3, 8, 8);
		imem[10] = addi(10, 0, 77);
		imem[11] = branch(1'b0, 3, 8, 8);
		imem[12] = addi(11, 0, 88);
		imem[13] = jal(0, 0);
		start_program();
		compare_trace();
	endtask

	// forward branches and jumps only, so the program always ends
	task automatic random_program();
		int kind;
		int span;
		int rd;
		int rs1;
		int rs2;
		clear_program();
		for (int i = 0; i < 40; i++) begin
			kind = $urandom_range(9);
			span = $urandom_range((40 - i < 4) ? 40 - i : 4, 1);
			rd = $urandom_range(7);
			rs1 = $urandom_range(7);
			rs2 = $urandom_range(7);
			case (kind)
				0: imem[i] = alu_rr(7'h00, 3'b000, rd, rs1, rs2);
				1: imem[i] = alu_rr(7'h20, 3'b000, rd, rs1, rs2);
				2: imem[i] = alu_rr(7'h00, 3'b111, rd, rs1, rs2);
				3: imem[i] = alu_rr(7'h00, 3'b110, rd, rs1, rs2);
				4: imem[i] = alu_rr(7'h00, 3'b100, rd, rs1, rs2);
				5: imem[i] = alu_rr(7'h00, 3'b010, rd, rs1, rs2);
				6: imem[i] = addi(rd, rs1, $urandom_range(4095));
				7: imem[i] = lui(rd, $urandom);
				8: imem[i] = branch($urandom_range(1), rs1, rs2, span * 4);
				default: imem[i] = jal(rd, span * 4);
			endcase
		end
		imem[40] = jal(0, 0);
		start_program();
		compare_trace();
	endtask

	initial begin
		int cycles;
		cycles = 0;
		while (cycles <= budget) begin
			@(posedge clk);
			cycles++;
		end
		$display("watchdog expired after %0d cycles", cycles);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation timed out");
	end

	initial begin
		void'($urandom(32'h1f7b_7f9c));
		rstn = 1'b0;
		clear_program();
		reset_state();
		dependent_alu();
		x0_writes();
		jal_skip();
		branch_loops();
		random_program();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: build.f
+incdir+design
+incdir+testbench
design/rv_pkg.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_hazard.sv
design/rv_execute.sv
design/rv_core.sv
testbench/tb_clkgen.sv
testbench/tb_rv_core.sv
